/* Bender.yml */
package:
  name: riscv_periph

sources:
  - riscv_periph_pkg.sv
  - riscv_rst_sync.sv
  - riscv_button_debouncer.sv
  - uart_tx_fifo.sv
  - uart_baud_gen.sv
  - uart_tx_serializer.sv
  - riscv_periph_top.sv
  - target: test
    files:
      - riscv_periph_assert.sv
      - tb_riscv_periph_top.sv

/* files.f */
riscv_periph_pkg.sv
riscv_rst_sync.sv
riscv_button_debouncer.sv
uart_tx_fifo.sv
uart_baud_gen.sv
uart_tx_serializer.sv
riscv_periph_top.sv
riscv_periph_assert.sv
tb_riscv_periph_top.sv

/* riscv_button_debouncer.sv */
`timescale 1ns/1ps

module riscv_button_debouncer #(
  parameter int unsigned DEBOUNCE_CYCLES = 65536
) (
  input  logic i_riscv_clk,
  input  logic i_arst_n   ,
  input  logic i_noisy    ,
  output logic o_debounced
);

  // Counter just wide enough to reach DEBOUNCE_CYCLES
  localparam int unsigned CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

  logic             noisy_meta;
  logic             noisy_sync;
  logic [CNT_W-1:0] stable_cnt;
  logic             debounced_q;

  // Two-flop synchronizer for the raw button level
  always_ff @(posedge i_riscv_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      noisy_meta <= 1'b0;
      noisy_sync <= 1'b0;
    end else begin
      noisy_meta <= i_noisy;
      noisy_sync <= noisy_meta;
    end
  end

  // The counter only runs while the synchronized input disagrees with the output.
  // Any return to the output value clears it, so a glitch never accumulates
  always_ff @(posedge i_riscv_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      stable_cnt  <= '0;
      debounced_q <= 1'b0;
    end else if (noisy_sync != debounced_q) begin
      if (stable_cnt == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
        stable_cnt  <= '0;
        debounced_q <= noisy_sync;
      end else begin
        stable_cnt <= stable_cnt + CNT_W'(1);
      end
    end else begin
      stable_cnt <= '0;
    end
  end

  assign o_debounced = debounced_q;

endmodule

/* riscv_periph_assert.sv */
`timescale 1ns/1ps

module riscv_periph_assert (
  input logic i_riscv_clk,
  input logic i_rst_n    ,
  input logic i_tx_serial,
  input logic i_busy     ,
  input logic i_pop      ,
  input logic i_baud_run ,
  input logic i_bit_tick
);

  // The line idles high whenever no frame is in flight
  idle_line_high: assert property (
    @(posedge i_riscv_clk) disable iff (!i_rst_n) !i_busy |-> i_tx_serial
  ) else $error("serial line is low while the transmitter is idle");

  // A pop moves the serializer out of idle, so it cannot repeat
  pop_single_cycle: assert property (
    @(posedge i_riscv_clk) disable iff (!i_rst_n) i_pop |=> !i_pop
  ) else $error("FIFO pop lasted more than one cycle");

  tick_only_when_running: assert property (
    @(posedge i_riscv_clk) disable iff (!i_rst_n) !i_baud_run |-> !i_bit_tick
  ) else $error("bit tick seen while the baud generator is stopped");

endmodule

bind riscv_periph_top riscv_periph_assert u_periph_assert (
  .i_riscv_clk(i_riscv_clk),
  .i_rst_n    (rst_n      ),
  .i_tx_serial(o_tx_serial),
  .i_busy     (tx_busy    ),
  .i_pop      (tx_pop     ),
  .i_baud_run (baud_run   ),
  .i_bit_tick (bit_tick   )
);

/* riscv_periph_pkg.sv */
package riscv_periph_pkg;

  // One payload byte as it enters the transmit path
  typedef logic [7:0] tx_byte_t;

  // FIFO occupancy, wide enough for any depth up to 32768 entries
  typedef logic [15:0] fifo_count_t;

  // Baud divisor and the running baud counter
  typedef logic [19:0] baud_cnt_t;

  // Head of the transmit FIFO as seen by the serializer
  typedef struct packed {
    logic     empty;
    tx_byte_t data;
  } fifo_rd_t;

  // Transmitter status reported at the top level
  typedef struct packed {
    logic busy;
    logic fifo_full;
  } tx_status_t;

  // Serializer frame states, one per kind of bit on the line
  typedef enum logic [2:0] {
    TX_IDLE   = 3'd0,
    TX_START  = 3'd1,
    TX_DATA   = 3'd2,
    TX_PARITY = 3'd3,
    TX_STOP   = 3'd4
  } tx_state_e;

endpackage

/* riscv_periph_top.sv */
`timescale 1ns/1ps

module riscv_periph_top #(
  parameter int                          FIFO_DEPTH      = 16      ,
  parameter riscv_periph_pkg::baud_cnt_t BAUD_DIVISOR    = 20'd6945,
  parameter logic                        PAR_EN          = 1'b1    ,
  parameter logic                        PAR_TYPE        = 1'b0    ,
  parameter int unsigned                 DEBOUNCE_CYCLES = 65536
) (
  input  logic                         i_riscv_clk         ,
  input  logic                         i_arst_n            ,
  input  logic                         i_tx_valid          ,
  input  riscv_periph_pkg::tx_byte_t   i_tx_data           ,
  input  logic                         i_external_interrupt,
  output logic                         o_tx_serial         ,
  output riscv_periph_pkg::tx_status_t o_tx_status         ,
  output logic                         o_irq_debounced
);

  logic                       rst_n    ;
  riscv_periph_pkg::fifo_rd_t fifo_rd  ;
  logic                       fifo_full;
  logic                       tx_pop   ;
  logic                       baud_run ;
  logic                       bit_tick ;
  logic                       tx_busy  ;

  // All blocks below share the synchronized reset
  riscv_rst_sync u_rst_sync (
    .i_riscv_clk(i_riscv_clk),
    .i_arst_n   (i_arst_n   ),
    .o_rst_n    (rst_n      )
  );

  riscv_button_debouncer #(
    .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
  ) u_button_debouncer (
    .i_riscv_clk(i_riscv_clk         ),
    .i_arst_n   (rst_n               ),
    .i_noisy    (i_external_interrupt),
    .o_debounced(o_irq_debounced     )
  );

  // Strobes go straight in, the FIFO drops them while full
  uart_tx_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_tx_fifo (
    .i_riscv_clk(i_riscv_clk),
    .i_arst_n   (rst_n      ),
    .i_wr_en    (i_tx_valid ),
    .i_wr_data  (i_tx_data  ),
    .i_pop      (tx_pop     ),
    .o_rd       (fifo_rd    ),
    .o_full     (fifo_full  )
  );

  uart_baud_gen #(
    .BAUD_DIVISOR(BAUD_DIVISOR)
  ) u_baud_gen (
    .i_riscv_clk(i_riscv_clk),
    .i_arst_n   (rst_n      ),
    .i_run      (baud_run   ),
    .o_bit_tick (bit_tick   )
  );

  uart_tx_serializer #(
    .PAR_EN  (PAR_EN  ),
    .PAR_TYPE(PAR_TYPE)
  ) u_tx_serializer (
    .i_riscv_clk(i_riscv_clk),
    .i_arst_n   (rst_n      ),
    .i_rd       (fifo_rd    ),
    .i_bit_tick (bit_tick   ),
    .o_pop      (tx_pop     ),
    .o_baud_run (baud_run   ),
    .o_tx_serial(o_tx_serial),
    .o_busy     (tx_busy    )
  );

  assign o_tx_status.busy      = tx_busy;
  assign o_tx_status.fifo_full = fifo_full;

endmodule

/* riscv_rst_sync.sv */
`timescale 1ns/1ps

module riscv_rst_sync (
  input  logic i_riscv_clk,
  input  logic i_arst_n   ,
  output logic o_rst_n
);

  logic rst_meta;
  logic rst_q   ;

  // Assert at once on the falling reset, release two clock edges later
  always_ff @(posedge i_riscv_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rst_meta <= 1'b0;
      rst_q    <= 1'b0;
    end else begin
      rst_meta <= 1'b1;
      rst_q    <= rst_meta;
    end
  end

  assign o_rst_n = rst_q;

endmodule

/* tb_riscv_periph_top.sv */
`timescale 1ns/1ps

module tb_riscv_periph_top;

  localparam int         FIFO_DEPTH  = 4;
  localparam int         BAUD        = 4;
  localparam int         DEB_CYCLES  = 16;
  localparam int         NUM_STEPS   = 13;
  localparam logic [1:0] STEP_BYTE   = 2'd0;
  localparam logic [1:0] STEP_BURST  = 2'd1;
  localparam logic [1:0] STEP_BUTTON = 2'd2;

  // One table row with the expected debounced level once the row is done
  typedef struct packed {
    logic [1:0]  kind;
    logic [7:0]  data;
    logic [15:0] hold;
    logic        irq_exp;
  } step_t;

  logic                         clk;
  logic                         arst_n;
  logic                         tx_valid;
  riscv_periph_pkg::tx_byte_t   tx_data;
  logic                         ext_irq;
  logic                         ser_even;
  logic                         ser_odd;
  logic                         irq_even;
  logic                         irq_odd;
  riscv_periph_pkg::tx_status_t status_even;
  riscv_periph_pkg::tx_status_t status_odd;
  step_t                        steps [NUM_STEPS];
  riscv_periph_pkg::tx_byte_t   exp_even [$];
  riscv_periph_pkg::tx_byte_t   exp_odd [$];
  integer                       seed;
  int                           cycle_cnt = 0;
  int                           timeout_limit = 0;
  int                           accepted_even = 0;
  int                           accepted_odd = 0;

  riscv_periph_top #(
    .FIFO_DEPTH(FIFO_DEPTH), .BAUD_DIVISOR(20'(BAUD)), .PAR_EN(1'b1),
    .PAR_TYPE(1'b0), .DEBOUNCE_CYCLES(DEB_CYCLES)
  ) dut_i (
    .i_riscv_clk(clk), .i_arst_n(arst_n), .i_tx_valid(tx_valid), .i_tx_data(tx_data),
    .i_external_interrupt(ext_irq), .o_tx_serial(ser_even), .o_tx_status(status_even),
    .o_irq_debounced(irq_even)
  );

  // The odd-parity instance sees the same stimulus
  riscv_periph_top #(
    .FIFO_DEPTH(FIFO_DEPTH), .BAUD_DIVISOR(20'(BAUD)), .PAR_EN(1'b1),
    .PAR_TYPE(1'b1), .DEBOUNCE_CYCLES(DEB_CYCLES)
  ) tb_odd (
    .i_riscv_clk(clk), .i_arst_n(arst_n), .i_tx_valid(tx_valid), .i_tx_data(tx_data),
    .i_external_interrupt(ext_irq), .o_tx_serial(ser_odd), .o_tx_status(status_odd),
    .o_irq_debounced(irq_odd)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (timeout_limit != 0 && cycle_cnt >= timeout_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
      $display("Simulation failed");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run aborted");
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  function automatic logic line_of(input int inst);
    return (inst == 0) ? ser_even : ser_odd;
  endfunction

  function automatic logic busy_of(input int inst);
    return (inst == 0) ? status_even.busy : status_odd.busy;
  endfunction

  // Even parity bit of a byte, set when the byte holds an odd number of ones
  function automatic logic even_parity(input riscv_periph_pkg::tx_byte_t b);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++) begin
      ones += b[i];
    end
    return (ones % 2) == 1;
  endfunction

  // A strobe is expected on the line only if the FIFO reported room at that edge
  task automatic write_byte(input riscv_periph_pkg::tx_byte_t b);
    tx_valid = 1'b1;
    tx_data  = b;
    if (!status_even.fifo_full) begin
      exp_even.push_back(b);
      accepted_even++;
    end
    if (!status_odd.fifo_full) begin
      exp_odd.push_back(b);
      accepted_odd++;
    end
    next_cycle();
    tx_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_even.size() != 0 || exp_odd.size() != 0 ||
           status_even.busy || status_odd.busy) begin
      next_cycle();
    end
  endtask

  task automatic check_idle();
    check_value("dut_i.o_tx_serial", ser_even, 1'b1);
    check_value("dut_i.o_tx_status", status_even, 2'b00);
    check_value("dut_i.o_irq_debounced", irq_even, 1'b0);
    check_value("tb_odd.o_tx_serial", ser_odd, 1'b1);
    check_value("tb_odd.o_tx_status", status_odd, 2'b00);
    check_value("tb_odd.o_irq_debounced", irq_odd, 1'b0);
  endtask

  // The serial decoder samples the line on falling clock edges near the middle of each bit
  task automatic decode_loop(input int inst);
    string                      nm;
    riscv_periph_pkg::tx_byte_t rx_byte;
    riscv_periph_pkg::tx_byte_t exp_byte;
    int                         b;
    nm = (inst == 0) ? "dut_i" : "tb_odd";
    forever begin
      @(negedge clk);
      if (line_of(inst) === 1'b0) begin
        repeat (BAUD / 2 - 1) @(negedge clk);
        check_value({nm, ".o_tx_serial start bit"}, line_of(inst), 1'b0);
        for (b = 0; b < 8; b++) begin
          repeat (BAUD) @(negedge clk);
          rx_byte[b] = line_of(inst);
          check_value({nm, ".o_tx_status.busy"}, busy_of(inst), 1'b1);
        end
        if ((inst == 0 && exp_even.size() == 0) || (inst == 1 && exp_odd.size() == 0)) begin
          fail_run({nm, " sent a frame although no accepted byte was waiting"});
        end
        if (inst == 0) begin
          exp_byte = exp_even.pop_front();
        end else begin
          exp_byte = exp_odd.pop_front();
        end
        check_value({nm, ".o_tx_serial data"}, rx_byte, exp_byte);
        repeat (BAUD) @(negedge clk);
        // Odd parity is the inverse of the even parity of the byte
        check_value({nm, ".o_tx_serial parity"}, line_of(inst),
                    even_parity(exp_byte) ^ (inst == 1));
        repeat (BAUD) @(negedge clk);
        check_value({nm, ".o_tx_serial stop bit"}, line_of(inst), 1'b1);
        repeat (BAUD / 2) begin
          @(negedge clk);
          check_value({nm, ".o_tx_status.busy"}, busy_of(inst), 1'b1);
        end
        // First cycle after the stop bit is idle
        @(negedge clk);
        check_value({nm, ".o_tx_status.busy"}, busy_of(inst), 1'b0);
      end
    end
  endtask

  initial begin
    wait (arst_n === 1'b1);
    decode_loop(0);
  end

  initial begin
    wait (arst_n === 1'b1);
    decode_loop(1);
  end

  initial begin
    int n_bytes;
    int hold_sum;
    int k;
    arst_n   = 1'b0;
    tx_valid = 1'b0;
    tx_data  = '0;
    ext_irq  = 1'b0;
    seed     = 32'hde83;
    n_bytes  = 0;
    hold_sum = 0;
    steps[0]  = '{STEP_BYTE, 8'h55, 16'd0, 1'b0};
    steps[1]  = '{STEP_BYTE, 8'ha3, 16'd0, 1'b0};
    steps[2]  = '{STEP_BYTE, 8'h00, 16'd0, 1'b0};
    steps[3]  = '{STEP_BURST, 8'h3c, 16'd0, 1'b0};
    steps[4]  = '{STEP_BUTTON, 8'h01, 16'd6, 1'b0};
    steps[5]  = '{STEP_BUTTON, 8'h00, 16'd4, 1'b0};
    steps[6]  = '{STEP_BUTTON, 8'h01, 16'd9, 1'b0};
    steps[7]  = '{STEP_BUTTON, 8'h00, 16'd3, 1'b0};
    steps[8]  = '{STEP_BUTTON, 8'h01, 16'(DEB_CYCLES + 6), 1'b1};
    steps[9]  = '{STEP_BUTTON, 8'h00, 16'd2, 1'b1};
    steps[10] = '{STEP_BUTTON, 8'h01, 16'd5, 1'b1};
    steps[11] = '{STEP_BUTTON, 8'h00, 16'(DEB_CYCLES + 6), 1'b0};
    steps[12] = '{STEP_BYTE, 8'h81, 16'd0, 1'b0};
    for (k = 0; k < NUM_STEPS; k++) begin
      n_bytes  += (steps[k].kind == STEP_BURST) ? 7 : (steps[k].kind == STEP_BYTE) ? 1 : 0;
      hold_sum += steps[k].hold;
    end
    timeout_limit = 10 + n_bytes * (11 * BAUD + 2) + hold_sum + 200;
    repeat (5) @(posedge clk);
    check_idle();
    repeat (5) @(posedge clk);
    #1;
    arst_n = 1'b1;
    repeat (3) next_cycle();
    check_idle();
    for (k = 0; k < NUM_STEPS; k++) begin
      case (steps[k].kind)
        STEP_BYTE: begin
          write_byte(steps[k].data);
          wait_drain();
        end
        STEP_BURST: begin
          accepted_even = 0;
          accepted_odd  = 0;
          write_byte(steps[k].data);
          repeat (6) write_byte(riscv_periph_pkg::tx_byte_t'($random(seed)));
          // The first byte leaves for the serializer at once and the rest fill the FIFO
          check_value("dut_i accepted burst bytes", accepted_even, FIFO_DEPTH + 1);
          check_value("tb_odd accepted burst bytes", accepted_odd, FIFO_DEPTH + 1);
          wait_drain();
        end
        default: begin
          ext_irq = steps[k].data[0];
          repeat (steps[k].hold) begin
            next_cycle();
            // A glitch must never reach the debounced output
            if (steps[k].hold < DEB_CYCLES) begin
              check_value("dut_i.o_irq_debounced", irq_even, steps[k].irq_exp);
            end
          end
          check_value("dut_i.o_irq_debounced", irq_even, steps[k].irq_exp);
          check_value("tb_odd.o_irq_debounced", irq_odd, steps[k].irq_exp);
        end
      endcase
    end
    wait_drain();
    repeat (4) next_cycle();
    check_idle();
    $display("Simulation passed");
    $finish;
  end

endmodule

/* uart_baud_gen.sv */
`timescale 1ns/1ps

module uart_baud_gen #(
  parameter riscv_periph_pkg::baud_cnt_t BAUD_DIVISOR = 20'd6945
) (
  input  logic i_riscv_clk,
  input  logic i_arst_n   ,
  input  logic i_run      ,
  output logic o_bit_tick
);

  riscv_periph_pkg::baud_cnt_t baud_cnt;
  logic                        cnt_last;

  assign cnt_last = (baud_cnt == BAUD_DIVISOR - riscv_periph_pkg::baud_cnt_t'(1));

  // Held at zero while idle so each frame starts with a full bit period
  always_ff @(posedge i_riscv_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      baud_cnt <= '0;
    end else if (!i_run || cnt_last) begin
      baud_cnt <= '0;
    end else begin
      baud_cnt <= baud_cnt + riscv_periph_pkg::baud_cnt_t'(1);
    end
  end

  assign o_bit_tick = i_run & cnt_last;

endmodule

/* uart_tx_fifo.sv */
`timescale 1ns/1ps

module uart_tx_fifo #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                         i_riscv_clk,
  input  logic                         i_arst_n   ,
  input  logic                         i_wr_en    ,
  input  riscv_periph_pkg::tx_byte_t   i_wr_data  ,
  input  logic                         i_pop      ,
  output riscv_periph_pkg::fifo_rd_t   o_rd       ,
  output logic                         o_full
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  riscv_periph_pkg::tx_byte_t    mem [FIFO_DEPTH];
  logic [PTR_W-1:0]              wr_ptr;
  logic [PTR_W-1:0]              rd_ptr;
  riscv_periph_pkg::fifo_count_t count ;
  logic                          full  ;
  logic                          empty ;
  logic                          do_wr ;
  logic                          do_rd ;

  assign full  = (count == riscv_periph_pkg::fifo_count_t'(FIFO_DEPTH));
  assign empty = (count == '0);

  // Writes into a full FIFO are dropped here
  assign do_wr = i_wr_en & ~full;
  assign do_rd = i_pop & ~empty;

  // Storage array
  always_ff @(posedge i_riscv_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= i_wr_data;
    end
  end

  // Pointers wrap naturally since the depth is a power of two
  always_ff @(posedge i_riscv_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + PTR_W'(1);
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + PTR_W'(1);
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + riscv_periph_pkg::fifo_count_t'(1);
        2'b01:   count <= count - riscv_periph_pkg::fifo_count_t'(1);
        default: count <= count;
      endcase
    end
  end

  // Head of queue is presented without a read latency
  assign o_rd.empty = empty;
  assign o_rd.data  = mem[rd_ptr];
  assign o_full     = full;

endmodule

/* uart_tx_serializer.sv */
`timescale 1ns/1ps

module uart_tx_serializer #(
  parameter logic PAR_EN   = 1'b1,
  parameter logic PAR_TYPE = 1'b0
) (
  input  logic                       i_riscv_clk,
  input  logic                       i_arst_n   ,
  input  riscv_periph_pkg::fifo_rd_t i_rd       ,
  input  logic                       i_bit_tick ,
  output logic                       o_pop      ,
  output logic                       o_baud_run ,
  output logic                       o_tx_serial,
  output logic                       o_busy
);

  riscv_periph_pkg::tx_state_e state_q ;
  riscv_periph_pkg::tx_byte_t  shift_q ;
  logic                        parity_q;
  logic [2:0]                  bit_idx ;
  logic                        tx_line ;
  logic                        pop     ;
  logic                        shift_en;

  // Pop as soon as the line is idle and a byte is waiting
  assign pop = (state_q == riscv_periph_pkg::TX_IDLE) & ~i_rd.empty;

  // Each start or data tick puts the next data bit on the line
  assign shift_en = i_bit_tick & ((state_q == riscv_periph_pkg::TX_START) |
                                  (state_q == riscv_periph_pkg::TX_DATA));

  // Byte and parity are captured on the pop, then shifted out LSB first
  always_ff @(posedge i_riscv_clk) begin
    if (pop) begin
      shift_q  <= i_rd.data;
      parity_q <= (^i_rd.data) ^ PAR_TYPE;
    end else if (shift_en) begin
      shift_q <= shift_q >> 1;
    end
  end

  // The line value is registered together with the state, so it changes on the
  // same edge as the tick that ends the previous bit
  always_ff @(posedge i_riscv_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= riscv_periph_pkg::TX_IDLE;
      bit_idx <= '0;
      tx_line <= 1'b1;
    end else begin
      case (state_q)
        riscv_periph_pkg::TX_IDLE: begin
          if (pop) begin
            state_q <= riscv_periph_pkg::TX_START;
            tx_line <= 1'b0;
          end
        end
        riscv_periph_pkg::TX_START: begin
          if (i_bit_tick) begin
            state_q <= riscv_periph_pkg::TX_DATA;
            bit_idx <= '0;
            tx_line <= shift_q[0];
          end
        end
        riscv_periph_pkg::TX_DATA: begin
          if (i_bit_tick) begin
            if (bit_idx == 3'd7) begin
              if (PAR_EN) begin
                state_q <= riscv_periph_pkg::TX_PARITY;
                tx_line <= parity_q;
              end else begin
                state_q <= riscv_periph_pkg::TX_STOP;
                tx_line <= 1'b1;
              end
            end else begin
              bit_idx <= bit_idx + 3'd1;
              tx_line <= shift_q[0];
            end
          end
        end
        riscv_periph_pkg::TX_PARITY: begin
          if (i_bit_tick) begin
            state_q <= riscv_periph_pkg::TX_STOP;
            tx_line <= 1'b1;
          end
        end
        riscv_periph_pkg::TX_STOP: begin
          // Line is already high, the frame ends with this tick
          if (i_bit_tick) begin
            state_q <= riscv_periph_pkg::TX_IDLE;
          end
        end
        default: begin
          state_q <= riscv_periph_pkg::TX_IDLE;
          tx_line <= 1'b1;
        end
      endcase
    end
  end

  assign o_pop       = pop;
  assign o_baud_run  = (state_q != riscv_periph_pkg::TX_IDLE);
  assign o_busy      = (state_q != riscv_periph_pkg::TX_IDLE);
  assign o_tx_serial = tx_line;

endmodule
